//--- Makefile
# Verilator build and run of the translation unit regression

VERILATOR ?= verilator
TOP       ?= mmu_tb
FILELIST  ?= mmu.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= Regression passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Overridable: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS RUN_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- mmu.f
mmu_pkg.sv
mmu_tlb.sv
mmu_ptw.sv
mmu_ctrl.sv
mmu_top.sv
mmu_assertions.sv
mmu_tb.sv

//--- mmu_assertions.sv
// Protocol and timing checker bound to the address translation unit top level
`timescale 1ns/1ps

module mmu_assertions import mmu_pkg::*; (
    input logic               clk,
    input logic               rst_n,
    input logic               req_valid,
    input logic [vpn_w-1:0]   req_vpn,
    input logic               req_ack,
    input logic               resp_valid,
    input xlate_resp_t        resp,
    input logic               satp_mode,
    input logic [ppn_w-1:0]   satp_ppn,
    input logic               mem_req,
    input logic [paddr_w-1:0] mem_addr,
    input logic               mem_done
);

    int unsigned      fail_count = 0;
    logic             accept;
    logic [vpn_w-1:0] vpn_q;      // Request under translation

    assign accept = req_valid && req_ack;

    always_ff @(posedge clk) begin
        if (accept) begin
            vpn_q <= req_vpn;
        end
    end

    reset_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !$past(rst_n) |-> req_ack && !mem_req && !resp_valid)
        else begin
            fail_count++;
            $error("Unit is not idle in the first cycle after reset");
        end

    bypass_identity: assert property (@(posedge clk) disable iff (!rst_n)
        $past(accept && !satp_mode) |-> resp_valid && !mem_req
            && resp.ppn == {{(ppn_w - vpn_w){1'b0}}, vpn_q}
            && !resp.pagefault && !resp.accessfault)
        else begin
            fail_count++;
            $error("Bypass response missing or not identity mapped");
        end

    walk_first_addr: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req && !$past(mem_req) |-> mem_addr == {satp_ppn, vpn_q[19:10], 2'b00})
        else begin
            fail_count++;
            $error("First table read not at the root entry of the request");
        end

    // Two cycles after a translated request either the hit answers or the walk has started
    hit_no_walk: assert property (@(posedge clk) disable iff (!rst_n)
        $past(accept && satp_mode, 2) |-> (resp_valid && !mem_req && !$past(mem_req))
            || (!resp_valid && mem_req))
        else begin
            fail_count++;
            $error("TLB hit response overlaps a memory read");
        end

    fault_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid |-> !(resp.pagefault && resp.accessfault))
        else begin
            fail_count++;
            $error("Page fault and access fault reported together");
        end

    addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        $past(mem_req && !mem_done) |-> mem_req && mem_addr == $past(mem_addr))
        else begin
            fail_count++;
            $error("Memory request dropped or address changed before done");
        end

    ack_busy: assert property (@(posedge clk) disable iff (!rst_n)
        $past(accept) || (!$past(req_ack) && !$past(resp_valid)) || resp_valid |-> !req_ack)
        else begin
            fail_count++;
            $error("Request acknowledge high while a translation is in flight");
        end

endmodule

bind mmu_top mmu_assertions u_assertions (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid  (req_valid),
    .req_vpn    (req_vpn),
    .req_ack    (req_ack),
    .resp_valid (resp_valid),
    .resp       (resp),
    .satp_mode  (satp_mode),
    .satp_ppn   (satp_ppn),
    .mem_req    (mem_req),
    .mem_addr   (mem_addr),
    .mem_done   (mem_done)
);

//--- mmu_ctrl.sv
// Translation sequencer that accepts requests, checks the TLB, starts walks and checks permissions
`timescale 1ns/1ps

module mmu_ctrl import mmu_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             req_valid,
    input  logic [vpn_w-1:0] req_vpn,
    input  access_t          req_access,
    output logic             req_ack,
    output logic             resp_valid,
    output xlate_resp_t      resp,
    input  logic             satp_mode,
    output logic [vpn_w-1:0] lookup_vpn,
    input  logic             lookup_hit,
    input  walk_result_t     lookup_entry,
    output logic             refill_en,
    output logic [vpn_w-1:0] refill_vpn,
    output walk_result_t     refill_entry,
    output logic             walk_start,
    output logic [vpn_w-1:0] walk_vpn,
    input  logic             walk_done,
    input  walk_result_t     walk_result
);

    typedef enum logic [1:0] {
        st_idle,
        st_lookup,
        st_walk,
        st_respond
    } ctrl_state_t;

    ctrl_state_t      state;
    logic [vpn_w-1:0] vpn_q;
    access_t          acc_q;
    xlate_resp_t      resp_q;

    logic         accept;
    logic         check_now;
    walk_result_t check_entry;
    xlate_resp_t  checked_resp;
    logic         allowed;

    function automatic logic perm_ok(input pte_flags_t flags, input access_t acc);
        case (acc)
            acc_read:  return flags.r;
            acc_write: return flags.w;
            acc_exec:  return flags.x;
            default:   return 1'b0;
        endcase
    endfunction

    assign req_ack    = state == st_idle;
    assign accept     = req_ack && req_valid;
    assign resp_valid = state == st_respond;
    assign resp       = resp_q;

    assign lookup_vpn = req_vpn;    // TLB registers it on the accepting edge
    assign walk_start = state == st_lookup && !lookup_hit;
    assign walk_vpn   = vpn_q;

    assign refill_en    = state == st_walk && walk_done
                          && !walk_result.pagefault && !walk_result.accessfault;
    assign refill_vpn   = vpn_q;
    assign refill_entry = walk_result;

    // Single checker shared by hit and walk paths
    assign check_entry = (state == st_walk) ? walk_result : lookup_entry;
    assign check_now   = (state == st_lookup && lookup_hit) || (state == st_walk && walk_done);
    assign allowed     = perm_ok(check_entry.flags, acc_q);

    always_comb begin
        checked_resp.accessfault = check_entry.accessfault;
        checked_resp.pagefault   = !check_entry.accessfault
                                   && (check_entry.pagefault || !allowed);
        checked_resp.ppn         = (checked_resp.pagefault || checked_resp.accessfault)
                                   ? '0 : check_entry.ppn;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:    if (accept) state <= satp_mode ? st_lookup : st_respond;
                st_lookup:  state <= lookup_hit ? st_respond : st_walk;
                st_walk:    if (walk_done) state <= st_respond;
                default:    state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            vpn_q <= req_vpn;
            acc_q <= req_access;
        end
        if (accept && !satp_mode) begin
            resp_q <= '{ppn: {{(ppn_w - vpn_w){1'b0}}, req_vpn}, pagefault: 1'b0,
                        accessfault: 1'b0};   // Identity map
        end else if (check_now) begin
            resp_q <= checked_resp;
        end
    end

endmodule

//--- mmu_pkg.sv
// Sv32 translation unit shared sizes, access kinds, PTE layout and result types
package mmu_pkg;

    localparam int vpn_w       = 20;
    localparam int ppn_w       = 22;
    localparam int paddr_w     = 34;
    localparam int tlb_entries = 16;
    localparam int tlb_idx_w   = 4;                 // Low VPN bits select the line
    localparam int tlb_tag_w   = vpn_w - tlb_idx_w;

    typedef enum logic [1:0] {
        acc_read  = 2'd0,
        acc_write = 2'd1,
        acc_exec  = 2'd2
    } access_t;

    typedef enum logic [1:0] {
        bus_okay = 2'd0,
        bus_err  = 2'd1
    } bus_resp_t;

    // Low byte of every PTE with v in bit 0
    typedef struct packed {
        logic d;
        logic a;
        logic g;
        logic u;
        logic x;
        logic w;
        logic r;
        logic v;
    } pte_flags_t;

    typedef struct packed {
        logic [11:0] ppn1;
        logic [9:0]  ppn0;
        logic [1:0]  rsw;
        pte_flags_t  flags;
    } pte_leaf_t;

    typedef struct packed {
        logic [ppn_w-1:0] next_ppn;   // Base of the next level table
        logic [1:0]       rsw;
        pte_flags_t       flags;
    } pte_ptr_t;

    // Same 32-bit word seen as leaf or as pointer
    typedef union packed {
        pte_leaf_t leaf;
        pte_ptr_t  ptr;
    } pte_t;

    typedef struct packed {
        logic [ppn_w-1:0] ppn;
        pte_flags_t       flags;
        logic             pagefault;
        logic             accessfault;
    } walk_result_t;

    typedef struct packed {
        logic [ppn_w-1:0] ppn;
        logic             pagefault;
        logic             accessfault;
    } xlate_resp_t;

endpackage

//--- mmu_ptw.sv
// Two-level Sv32 page table walker on a read-only memory port
`timescale 1ns/1ps

module mmu_ptw import mmu_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               walk_start,
    input  logic [vpn_w-1:0]   walk_vpn,
    input  logic [ppn_w-1:0]   satp_ppn,
    output logic               walk_done,
    output walk_result_t       walk_result,
    output logic               mem_req,
    output logic [paddr_w-1:0] mem_addr,
    input  logic               mem_done,
    input  bus_resp_t          mem_resp,
    input  pte_t               mem_rdata
);

    typedef enum logic {
        ptw_idle,
        ptw_walking
    } ptw_state_t;

    ptw_state_t       state;
    logic             level;        // 1 is the root table
    logic [ppn_w-1:0] table_base;
    logic [vpn_w-1:0] vpn_q;

    logic bus_error;
    logic pte_invalid;
    logic pte_leaf;
    logic pte_misaligned;
    logic descend;

    assign bus_error      = mem_resp != bus_okay;
    assign pte_invalid    = !mem_rdata.leaf.flags.v
                            || (!mem_rdata.leaf.flags.r && mem_rdata.leaf.flags.w);
    assign pte_leaf       = mem_rdata.leaf.flags.r || mem_rdata.leaf.flags.x;
    assign pte_misaligned = level && (mem_rdata.leaf.ppn0 != '0);

    assign mem_req  = state == ptw_walking;
    assign mem_addr = {table_base, level ? vpn_q[19:10] : vpn_q[9:0], 2'b00};

    always_comb begin
        descend                 = 1'b0;
        walk_result.ppn         = {mem_rdata.leaf.ppn1, level ? vpn_q[9:0] : mem_rdata.leaf.ppn0};
        walk_result.flags       = mem_rdata.leaf.flags;
        walk_result.pagefault   = 1'b0;
        walk_result.accessfault = 1'b0;
        if (bus_error) begin
            walk_result.accessfault = 1'b1;
        end else if (pte_invalid) begin
            walk_result.pagefault = 1'b1;
        end else if (pte_leaf) begin
            walk_result.pagefault = pte_misaligned;  // Megapage must be 4 MiB aligned
        end else if (!level) begin
            walk_result.pagefault = 1'b1;            // Pointer where a leaf is required
        end else begin
            descend = 1'b1;
        end
    end

    assign walk_done = mem_req && mem_done && !descend;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ptw_idle;
            level <= 1'b1;
        end else begin
            case (state)
                ptw_idle: begin
                    if (walk_start) begin
                        state <= ptw_walking;
                        level <= 1'b1;
                    end
                end
                ptw_walking: begin
                    if (mem_done) begin
                        if (descend) begin
                            level <= 1'b0;
                        end else begin
                            state <= ptw_idle;
                        end
                    end
                end
                default: state <= ptw_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ptw_idle && walk_start) begin
            vpn_q      <= walk_vpn;
            table_base <= satp_ppn;
        end else if (mem_req && mem_done && descend) begin
            table_base <= mem_rdata.ptr.next_ppn;
        end
    end

endmodule

//--- mmu_tb.sv
// Testbench for the address translation unit with a page table memory model
`timescale 1ns/1ps

module mmu_tb import mmu_pkg::*; ();

    localparam logic [ppn_w-1:0]   root_ppn   = 22'h00010;
    localparam logic [ppn_w-1:0]   l0_ppn     = 22'h00020;
    localparam logic [paddr_w-1:0] err_addr   = {root_ppn, 10'd6, 2'b00};
    localparam int                 n_requests = 24;

    logic               clk = 1'b0;
    logic               rst_n;
    logic               req_valid;
    logic [vpn_w-1:0]   req_vpn;
    access_t            req_access;
    logic               req_ack;
    logic               resp_valid;
    xlate_resp_t        resp;
    logic               satp_mode;
    logic [ppn_w-1:0]   satp_ppn;
    logic               mem_req;
    logic [paddr_w-1:0] mem_addr;
    logic               mem_done  = 1'b0;    // Memory model starts quiet
    bus_resp_t          mem_resp  = bus_okay;
    pte_t               mem_rdata = '0;

    logic [31:0]        pt_mem [logic [31:0]];   // Sparse word store
    integer             seed = 32'h7393_4dfd;
    logic               pending = 1'b0;
    int                 wait_cnt;
    int                 errors = 0;
    logic               cached_ok  [tlb_entries];
    logic [vpn_w-1:0]   cached_vpn [tlb_entries];

    mmu_top dut (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] read_word(input logic [paddr_w-1:0] addr);
        if (pt_mem.exists(addr[paddr_w-1:2])) begin
            return pt_mem[addr[paddr_w-1:2]];
        end
        return 32'h0;    // Unmapped words read as invalid PTEs
    endfunction

    task automatic put_pte(input logic [ppn_w-1:0] base, input logic [9:0] idx,
                           input logic [ppn_w-1:0] ppn, input logic [7:0] flags);
        pt_mem[{base, idx}] = {ppn, 2'b00, flags};
    endtask

    // Reference walk over the raw table words
    function automatic xlate_resp_t expect_xlate(input logic [vpn_w-1:0] vpn,
                                                 input access_t acc, output logic walk_ok);
        xlate_resp_t        r;
        logic [ppn_w-1:0]   base;
        logic [paddr_w-1:0] addr;
        logic [31:0]        pte;
        logic               allow;
        r       = '0;
        walk_ok = 1'b0;
        base    = root_ppn;
        for (int lvl = 1; lvl >= 0; lvl--) begin
            addr = {base, (lvl == 1) ? vpn[19:10] : vpn[9:0], 2'b00};
            pte  = read_word(addr);
            if (addr == err_addr) begin
                r.accessfault = 1'b1;
                return r;
            end
            if (!pte[0] || (pte[2] && !pte[1])) begin
                r.pagefault = 1'b1;
                return r;
            end
            if (pte[1] || pte[3]) begin
                if (lvl == 1 && pte[19:10] != 10'd0) begin
                    r.pagefault = 1'b1;    // Misaligned megapage
                    return r;
                end
                walk_ok     = 1'b1;
                allow       = (acc == acc_read) ? pte[1] : (acc == acc_write) ? pte[2] : pte[3];
                r.pagefault = !allow;
                r.ppn       = (lvl == 1) ? {pte[31:20], vpn[9:0]} : pte[31:10];
                return r;
            end
            if (lvl == 0) begin
                r.pagefault = 1'b1;
                return r;
            end
            base = pte[31:10];
        end
        return r;
    endfunction

    // Answers each table read after 1 to 4 cycles
    always @(posedge clk) begin
        mem_done <= 1'b0;
        if (mem_req && !mem_done) begin
            if (!pending) begin
                pending  <= 1'b1;
                wait_cnt <= $unsigned($random(seed)) % 4;
            end else if (wait_cnt == 0) begin
                pending   <= 1'b0;
                mem_done  <= 1'b1;
                mem_resp  <= (mem_addr == err_addr) ? bus_err : bus_okay;
                mem_rdata <= read_word(mem_addr);
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] want, input logic [vpn_w-1:0] vpn);
        if (got !== want) begin
            errors++;
            $display("Mismatch %s: got %h, expected %h (vpn %h)", name, got, want, vpn);
        end
    endtask

    task automatic translate(input logic mode, input logic [vpn_w-1:0] vpn, input access_t acc);
        xlate_resp_t want;
        logic        walk_ok;
        logic        hit_exp;
        int          lat;
        int          want_lat;
        lat     = 0;
        walk_ok = 1'b0;
        hit_exp = mode && cached_ok[vpn[tlb_idx_w-1:0]] && cached_vpn[vpn[tlb_idx_w-1:0]] == vpn;
        if (mode) begin
            want = expect_xlate(vpn, acc, walk_ok);
        end else begin
            want     = '0;
            want.ppn = {{(ppn_w - vpn_w){1'b0}}, vpn};
        end
        want_lat = !mode ? 1 : (hit_exp ? 2 : 0);    // 0 means a walk of any length
        @(posedge clk);
        req_valid  <= 1'b1;
        req_vpn    <= vpn;
        req_access <= acc;
        satp_mode  <= mode;
        @(negedge clk);
        while (!req_ack) @(negedge clk);
        @(posedge clk);
        req_valid <= 1'b0;
        do begin
            @(negedge clk);
            lat++;
        end while (!resp_valid);
        compare_value("resp.pagefault", 32'(resp.pagefault), 32'(want.pagefault), vpn);
        compare_value("resp.accessfault", 32'(resp.accessfault), 32'(want.accessfault), vpn);
        if (!want.pagefault && !want.accessfault) begin
            compare_value("resp.ppn", 32'(resp.ppn), 32'(want.ppn), vpn);
        end
        if ((want_lat != 0 && lat != want_lat) || (want_lat == 0 && lat <= 2)) begin
            errors++;
            $display("Wrong response latency for vpn %h: %0d cycles", vpn, lat);
        end
        if (mode && walk_ok) begin
            cached_ok[vpn[tlb_idx_w-1:0]]  = 1'b1;
            cached_vpn[vpn[tlb_idx_w-1:0]] = vpn;
        end
    endtask

    initial begin
        repeat (n_requests * 40) @(posedge clk);
        $display("Timeout: translations did not complete within %0d cycles", n_requests * 40);
        $display("Regression failed");
        $finish;
    end

    initial begin
        int total;
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req_vpn    = '0;
        req_access = acc_read;
        satp_mode  = 1'b0;
        satp_ppn   = root_ppn;
        for (int i = 0; i < tlb_entries; i++) begin
            cached_ok[i] = 1'b0;
        end
        put_pte(root_ppn, 10'd1, l0_ppn, 8'h01);              // Pointer to level 0
        put_pte(root_ppn, 10'd2, {12'h123, 10'h000}, 8'h0f);  // Megapage
        put_pte(root_ppn, 10'd3, {12'h456, 10'h005}, 8'h03);  // Misaligned megapage
        put_pte(root_ppn, 10'd4, 22'h00777, 8'h0e);           // V clear
        put_pte(root_ppn, 10'd5, 22'h00888, 8'h05);           // W without R
        put_pte(root_ppn, 10'd6, 22'h00999, 8'h03);           // Bus error slot
        put_pte(l0_ppn, 10'd1, 22'h00aaa, 8'h03);             // Read only
        put_pte(l0_ppn, 10'd2, 22'h00bbb, 8'h07);             // Read write
        put_pte(l0_ppn, 10'd3, 22'h00ccc, 8'h09);             // Execute only
        put_pte(l0_ppn, 10'd4, 22'h00040, 8'h01);             // Pointer at level 0
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        translate(1'b0, 20'h12345, acc_read);
        translate(1'b0, 20'hfffff, acc_write);
        translate(1'b0, 20'h00401, acc_exec);
        translate(1'b1, 20'h00401, acc_write);
        translate(1'b1, 20'h00401, acc_read);
        translate(1'b1, 20'h00401, acc_write);
        translate(1'b1, 20'h00402, acc_write);
        translate(1'b1, 20'h00402, acc_read);
        translate(1'b1, 20'h00403, acc_read);
        translate(1'b1, 20'h00403, acc_exec);
        translate(1'b1, 20'h00403, acc_read);
        translate(1'b1, 20'h00abc, acc_read);
        translate(1'b1, 20'h00abc, acc_exec);
        translate(1'b1, 20'h00c05, acc_read);
        translate(1'b1, 20'h00c05, acc_read);
        translate(1'b1, 20'h01000, acc_read);
        translate(1'b1, 20'h01400, acc_write);
        translate(1'b1, 20'h01800, acc_read);
        translate(1'b1, 20'h01800, acc_read);
        translate(1'b1, 20'h00404, acc_read);
        translate(1'b1, 20'h02000, acc_read);
        translate(1'b1, 20'h00811, acc_read);    // Evicts line 1
        translate(1'b1, 20'h00401, acc_read);
        translate(1'b1, 20'h00401, acc_read);

        repeat (3) @(posedge clk);
        total = errors + int'(dut.u_assertions.fail_count);
        $display("Errors: %0d response checks, %0d assertions", errors,
                 dut.u_assertions.fail_count);
        if (total == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- mmu_tlb.sv
// Direct-mapped TLB with a registered lookup port and a refill port
`timescale 1ns/1ps

module mmu_tlb import mmu_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [vpn_w-1:0] lookup_vpn,
    output logic             lookup_hit,
    output walk_result_t     lookup_entry,
    input  logic             refill_en,
    input  logic [vpn_w-1:0] refill_vpn,
    input  walk_result_t     refill_entry
);

    logic [tlb_entries-1:0] valid_q;
    logic [tlb_tag_w-1:0]   tag_mem   [tlb_entries];
    walk_result_t           entry_mem [tlb_entries];

    logic [tlb_idx_w-1:0] lookup_idx;
    logic [tlb_tag_w-1:0] lookup_tag;
    logic [tlb_idx_w-1:0] refill_idx;
    logic [tlb_tag_w-1:0] refill_tag;

    assign lookup_idx = lookup_vpn[tlb_idx_w-1:0];
    assign lookup_tag = lookup_vpn[vpn_w-1:tlb_idx_w];
    assign refill_idx = refill_vpn[tlb_idx_w-1:0];
    assign refill_tag = refill_vpn[vpn_w-1:tlb_idx_w];

    // Valid bits only cleared by reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (refill_en) begin
            valid_q[refill_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (refill_en) begin
            tag_mem[refill_idx]   <= refill_tag;
            entry_mem[refill_idx] <= refill_entry;
        end
    end

    // Lookup sees the old line if a refill lands in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lookup_hit <= 1'b0;
        end else begin
            lookup_hit <= valid_q[lookup_idx] && (tag_mem[lookup_idx] == lookup_tag);
        end
    end

    always_ff @(posedge clk) begin
        lookup_entry <= entry_mem[lookup_idx];
    end

endmodule

//--- mmu_top.sv
// Address translation unit top connecting sequencer, TLB and page table walker
`timescale 1ns/1ps

module mmu_top import mmu_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               req_valid,
    input  logic [vpn_w-1:0]   req_vpn,
    input  access_t            req_access,
    output logic               req_ack,
    output logic               resp_valid,
    output xlate_resp_t        resp,
    input  logic               satp_mode,
    input  logic [ppn_w-1:0]   satp_ppn,
    output logic               mem_req,
    output logic [paddr_w-1:0] mem_addr,
    input  logic               mem_done,
    input  bus_resp_t          mem_resp,
    input  pte_t               mem_rdata
);

    logic [vpn_w-1:0] lookup_vpn;
    logic             lookup_hit;
    walk_result_t     lookup_entry;
    logic             refill_en;
    logic [vpn_w-1:0] refill_vpn;
    walk_result_t     refill_entry;
    logic             walk_start;
    logic [vpn_w-1:0] walk_vpn;
    logic             walk_done;
    walk_result_t     walk_result;

    mmu_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .req_vpn      (req_vpn),
        .req_access   (req_access),
        .req_ack      (req_ack),
        .resp_valid   (resp_valid),
        .resp         (resp),
        .satp_mode    (satp_mode),
        .lookup_vpn   (lookup_vpn),
        .lookup_hit   (lookup_hit),
        .lookup_entry (lookup_entry),
        .refill_en    (refill_en),
        .refill_vpn   (refill_vpn),
        .refill_entry (refill_entry),
        .walk_start   (walk_start),
        .walk_vpn     (walk_vpn),
        .walk_done    (walk_done),
        .walk_result  (walk_result)
    );

    mmu_tlb u_tlb (
        .clk          (clk),
        .rst_n        (rst_n),
        .lookup_vpn   (lookup_vpn),
        .lookup_hit   (lookup_hit),
        .lookup_entry (lookup_entry),
        .refill_en    (refill_en),
        .refill_vpn   (refill_vpn),
        .refill_entry (refill_entry)
    );

    mmu_ptw u_ptw (
        .clk         (clk),
        .rst_n       (rst_n),
        .walk_start  (walk_start),
        .walk_vpn    (walk_vpn),
        .satp_ppn    (satp_ppn),
        .walk_done   (walk_done),
        .walk_result (walk_result),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_done    (mem_done),
        .mem_resp    (mem_resp),
        .mem_rdata   (mem_rdata)
    );

endmodule
